/* logic/decode_defines.svh */
// widths and lane count shared by the decode stage RTL
// include wherever a width or the lane count is needed
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// data and immediate width
`define DEC_XLEN 32

// pc of an instruction pair, byte address bits 31:2
`define DEC_PC_W 30

// one fetch word holds two instructions
`define DEC_BUNDLE_W 64

`define DEC_LANES 2

`define DEC_REG_W 5

`endif

/* logic/rv_isa_pkg.sv */
// RV32I instruction encoding types
// the lane decoder reads one instruction word through these views
`default_nettype none
`include "decode_defines.svh"

package rv_isa_pkg;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } rv_opcode_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`DEC_REG_W-1:0] rs2;
    logic [`DEC_REG_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`DEC_REG_W-1:0] rd;
    rv_opcode_e            opcode;
    logic [1:0]            low_bits;
  } rv_rtype_t;

  typedef struct packed {
    logic [19:0]           imm20;
    logic [`DEC_REG_W-1:0] rd;
    rv_opcode_e            opcode;
    logic [1:0]            low_bits;
  } rv_utype_t;

  // same word seen as register fields or as upper immediate
  typedef union packed {
    rv_rtype_t r;
    rv_utype_t u;
  } rv_instr_u;

endpackage

`default_nettype wire

/* logic/decode_pkg.sv */
// decoded micro-op types handed from decode to rename
// imported by the lane decoders, the issue register and the top level
`default_nettype none
`include "decode_defines.svh"

package decode_pkg;

  // execution unit that takes the instruction
  typedef enum logic [3:0] {
    UNIT_NONE   = 4'd0,
    UNIT_ALU    = 4'd1,
    UNIT_LUI    = 4'd2,
    UNIT_AUIPC  = 4'd3,
    UNIT_JAL    = 4'd4,
    UNIT_JALR   = 4'd5,
    UNIT_BRANCH = 4'd6,
    UNIT_LOAD   = 4'd7,
    UNIT_STORE  = 4'd8
  } dec_unit_e;

  typedef struct packed {
    dec_unit_e             unit;
    logic [3:0]            alu_op;
    logic [`DEC_REG_W-1:0] rs1;
    logic [`DEC_REG_W-1:0] rs2;
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_XLEN-1:0]  imm;
    logic                  use_imm;
    logic                  rd_wr;
    logic                  rs1_rd;
    logic                  rs2_rd;
    logic                  illegal;
  } dec_uop_t;

endpackage

`default_nettype wire

/* logic/fetch_bundle_if.sv */
// aligned fetch bundle from the skid buffer to the lanes and the issue register
// ready comes back from the issue register
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

interface fetch_bundle_if import rv_isa_pkg::*; ();
  logic                   vld;
  logic [`DEC_PC_W-1:0]   pc;
  rv_instr_u              slot_instr [`DEC_LANES];
  logic [`DEC_LANES-1:0]  slot_vld;
  logic                   ready;

  modport src   (output vld, pc, slot_instr, slot_vld, input ready);
  modport lane  (input slot_instr);
  modport issue (input vld, pc, slot_vld, output ready);
endinterface

`default_nettype wire

/* logic/fetch_skid_buffer.sv */
// one-entry skid buffer in front of decode
// holds a fetched bundle across a rename stall and aligns the instruction slots
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module fetch_skid_buffer (
  input  wire                      cpu_clk_i,
  input  wire                      rst_n_i,
  input  wire                      flush_i,
  input  wire                      fetch_vld_i,
  input  wire [`DEC_BUNDLE_W-1:0]  fetch_word_i,
  input  wire [`DEC_PC_W-1:0]      fetch_pc_i,
  output logic                     busy_o,
  fetch_bundle_if.src              bundle
);
  logic                      skid_full;
  logic [`DEC_BUNDLE_W-1:0]  skid_word;
  logic [`DEC_PC_W-1:0]      skid_pc;
  logic [`DEC_BUNDLE_W-1:0]  cur_word;
  logic [`DEC_PC_W-1:0]      cur_pc;
  logic                      stall_in;

  // accepted bundle that the issue stage cannot take this cycle
  assign stall_in = fetch_vld_i && !skid_full && !bundle.ready && !flush_i;

  always_ff @(posedge cpu_clk_i) begin
    if (!rst_n_i || flush_i) begin
      skid_full <= 1'b0;
    end else if (skid_full && bundle.ready) begin
      skid_full <= 1'b0;
    end else if (stall_in) begin
      skid_full <= 1'b1;
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (stall_in) begin
      skid_word <= fetch_word_i;
      skid_pc   <= fetch_pc_i;
    end
  end

  assign busy_o = skid_full;

  // the held entry goes first, otherwise pass the input through
  assign cur_word = skid_full ? skid_word : fetch_word_i;
  assign cur_pc   = skid_full ? skid_pc : fetch_pc_i;

  assign bundle.vld = skid_full || fetch_vld_i;
  assign bundle.pc  = cur_pc;

  // odd pc means only the upper instruction is live, so it moves to lane 0
  assign bundle.slot_instr[0] = cur_pc[0] ? cur_word[`DEC_BUNDLE_W-1 -: `DEC_XLEN]
                                          : cur_word[`DEC_XLEN-1:0];
  assign bundle.slot_instr[1] = cur_word[`DEC_BUNDLE_W-1 -: `DEC_XLEN];
  assign bundle.slot_vld      = cur_pc[0] ? {{(`DEC_LANES-1){1'b0}}, 1'b1}
                                          : {`DEC_LANES{1'b1}};

  // fetch holds off while the entry is occupied
  assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    skid_full |-> !fetch_vld_i);

endmodule

`default_nettype wire

/* logic/rv_lane_decoder.sv */
// combinational RV32I decoder for one lane of the bundle
// builds the micro-op: unit, alu opcode, immediate and register use
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module rv_lane_decoder
  import rv_isa_pkg::*, decode_pkg::*;
#(
  parameter int LANE = 0
) (
  fetch_bundle_if.lane bundle,
  output dec_uop_t     uop_o
);
  rv_instr_u             ins;
  logic [6:0]            f7;
  logic [2:0]            f3;
  logic [`DEC_XLEN-1:0]  imm_i;
  logic [`DEC_XLEN-1:0]  imm_s;
  logic [`DEC_XLEN-1:0]  imm_b;
  logic [`DEC_XLEN-1:0]  imm_u;
  logic [`DEC_XLEN-1:0]  imm_j;
  logic                  op_bad;
  logic                  shift_bad;
  logic                  fmt_bad;
  logic                  illegal;
  dec_unit_e             unit;
  logic [3:0]            alu_op;
  logic [`DEC_XLEN-1:0]  imm;
  logic                  use_imm;
  logic                  rs1_use;
  logic                  rs2_use;
  logic                  rd_use;

  assign ins = bundle.slot_instr[LANE];
  assign f7  = ins.r.funct7;
  assign f3  = ins.r.funct3;

  // I and S immediates sit in the funct7/rs2 and funct7/rd fields
  assign imm_i = {{(`DEC_XLEN-12){f7[6]}}, f7, ins.r.rs2};
  assign imm_s = {{(`DEC_XLEN-12){f7[6]}}, f7, ins.r.rd};
  assign imm_b = {{(`DEC_XLEN-12){f7[6]}}, ins.r.rd[0], f7[5:0], ins.r.rd[4:1], 1'b0};
  assign imm_u = {ins.u.imm20, 12'h000};
  assign imm_j = {{(`DEC_XLEN-20){ins.u.imm20[19]}}, ins.u.imm20[7:0], ins.u.imm20[8],
                  ins.u.imm20[18:9], 1'b0};

  // only add/sub and srl/sra may carry funct7 0x20
  assign op_bad = !((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
  // slli needs funct7 zero, srli and srai allow bit 5
  assign shift_bad = (f3 == 3'b001 && f7 != 7'h00) ||
                     (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);

  always_comb begin
    unit    = UNIT_NONE;
    alu_op  = {1'b0, f3};
    imm     = '0;
    use_imm = 1'b0;
    fmt_bad = 1'b0;
    rs1_use = 1'b1;
    rs2_use = 1'b0;
    rd_use  = 1'b0;
    case (ins.r.opcode)
      OPC_OP: begin
        unit    = UNIT_ALU;
        alu_op  = {f7[5], f3};
        fmt_bad = op_bad;
        rs2_use = 1'b1;
        rd_use  = 1'b1;
      end
      OPC_OP_IMM: begin
        unit    = UNIT_ALU;
        // bit 5 of funct7 is immediate data except for right shifts
        alu_op  = {f7[5] & (f3 == 3'b101), f3};
        imm     = imm_i;
        use_imm = 1'b1;
        fmt_bad = shift_bad;
        rd_use  = 1'b1;
      end
      OPC_LOAD: begin
        unit    = UNIT_LOAD;
        imm     = imm_i;
        fmt_bad = f3[2] & f3[1];
        rd_use  = 1'b1;
      end
      OPC_STORE: begin
        unit    = UNIT_STORE;
        imm     = imm_s;
        fmt_bad = f3 > 3'b010;
        rs2_use = 1'b1;
      end
      OPC_BRANCH: begin
        unit    = UNIT_BRANCH;
        imm     = imm_b;
        fmt_bad = f3[2:1] == 2'b01;
        rs2_use = 1'b1;
      end
      OPC_JALR: begin
        unit    = UNIT_JALR;
        imm     = imm_i;
        fmt_bad = f3 != 3'b000;
        rd_use  = 1'b1;
      end
      OPC_JAL: begin
        unit    = UNIT_JAL;
        imm     = imm_j;
        rs1_use = 1'b0;
        rd_use  = 1'b1;
      end
      OPC_LUI: begin
        unit    = UNIT_LUI;
        imm     = imm_u;
        rs1_use = 1'b0;
        rd_use  = 1'b1;
      end
      OPC_AUIPC: begin
        unit    = UNIT_AUIPC;
        imm     = imm_u;
        rs1_use = 1'b0;
        rd_use  = 1'b1;
      end
      default: begin
        fmt_bad = 1'b1;
      end
    endcase
  end

  // 16-bit encodings are not supported
  assign illegal = (ins.r.low_bits != 2'b11) || fmt_bad;

  always_comb begin
    uop_o.unit    = illegal ? UNIT_NONE : unit;
    uop_o.alu_op  = alu_op;
    uop_o.rs1     = ins.r.rs1;
    uop_o.rs2     = ins.r.rs2;
    uop_o.rd      = ins.r.rd;
    uop_o.imm     = imm;
    uop_o.use_imm = use_imm;
    // writes to x0 are dropped here so rename never allocates for them
    uop_o.rd_wr   = !illegal && rd_use && (ins.r.rd != '0);
    uop_o.rs1_rd  = !illegal && rs1_use;
    uop_o.rs2_rd  = !illegal && rs2_use;
    uop_o.illegal = illegal;
  end

endmodule

`default_nettype wire

/* logic/issue_register.sv */
// output register of the decode stage
// holds both micro-ops for rename and stalls while rename is busy
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module issue_register import decode_pkg::*; (
  input  wire                    cpu_clk_i,
  input  wire                    rst_n_i,
  input  wire                    flush_i,
  input  wire                    rn_busy_i,
  fetch_bundle_if.issue          bundle,
  input  wire dec_uop_t          uop_i [`DEC_LANES],
  output logic                   valid_o,
  output logic                   ins1_valid_o,
  output logic [`DEC_PC_W-1:0]   bundle_pc_o,
  output dec_uop_t               uop_o [`DEC_LANES]
);
  logic take;

  assign bundle.ready = !rn_busy_i;
  assign take = bundle.vld && !rn_busy_i;

  always_ff @(posedge cpu_clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_o <= 1'b0;
    end else if (!rn_busy_i) begin
      // an empty cycle drops valid
      valid_o <= bundle.vld;
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (take) begin
      bundle_pc_o  <= bundle.pc;
      ins1_valid_o <= bundle.slot_vld[1];
      uop_o        <= uop_i;
    end
  end

  // rename sees a frozen bundle for the whole stall
  assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    valid_o && rn_busy_i && !flush_i |=> valid_o && $stable(bundle_pc_o) &&
      $stable(ins1_valid_o) && $stable(uop_o[0]) && $stable(uop_o[1]));

endmodule

`default_nettype wire

/* logic/dual_decode_top.sv */
// dual-issue RV32I decode stage between fetch and rename
// fetch offers a bundle when busy_o is low; rename stalls with rn_busy_i
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module dual_decode_top import decode_pkg::*; (
  input  wire                       cpu_clk_i,
  input  wire                       rst_n_i,
  input  wire                       flush_i,
  input  wire                       icache_valid_i,
  input  wire [`DEC_BUNDLE_W-1:0]   instruction_i,
  input  wire [`DEC_PC_W-1:0]       if2_pc_i,
  input  wire                       rn_busy_i,
  output logic                      busy_o,
  output logic                      valid_o,
  output logic                      ins1_valid_o,
  output logic [`DEC_PC_W-1:0]      bundle_pc_o,
  output dec_unit_e                 ins0_unit_o,
  output logic [3:0]                ins0_alu_op_o,
  output logic [`DEC_REG_W-1:0]     ins0_rs1_o,
  output logic [`DEC_REG_W-1:0]     ins0_rs2_o,
  output logic [`DEC_REG_W-1:0]     ins0_rd_o,
  output logic [`DEC_XLEN-1:0]      ins0_imm_o,
  output logic                      ins0_use_imm_o,
  output logic                      ins0_rd_wr_o,
  output logic                      ins0_rs1_rd_o,
  output logic                      ins0_rs2_rd_o,
  output logic                      ins0_illegal_o,
  output dec_unit_e                 ins1_unit_o,
  output logic [3:0]                ins1_alu_op_o,
  output logic [`DEC_REG_W-1:0]     ins1_rs1_o,
  output logic [`DEC_REG_W-1:0]     ins1_rs2_o,
  output logic [`DEC_REG_W-1:0]     ins1_rd_o,
  output logic [`DEC_XLEN-1:0]      ins1_imm_o,
  output logic                      ins1_use_imm_o,
  output logic                      ins1_rd_wr_o,
  output logic                      ins1_rs1_rd_o,
  output logic                      ins1_rs2_rd_o,
  output logic                      ins1_illegal_o
);
  fetch_bundle_if bundle_if ();

  dec_uop_t uop_dec [`DEC_LANES];
  dec_uop_t uop_q   [`DEC_LANES];

  fetch_skid_buffer u_skid (
    .cpu_clk_i    (cpu_clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .fetch_vld_i  (icache_valid_i),
    .fetch_word_i (instruction_i),
    .fetch_pc_i   (if2_pc_i),
    .busy_o       (busy_o),
    .bundle       (bundle_if.src)
  );

  for (genvar l = 0; l < `DEC_LANES; l++) begin : g_lane
    rv_lane_decoder #(
      .LANE (l)
    ) u_lane (
      .bundle (bundle_if.lane),
      .uop_o  (uop_dec[l])
    );
  end

  issue_register u_issue (
    .cpu_clk_i    (cpu_clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .rn_busy_i    (rn_busy_i),
    .bundle       (bundle_if.issue),
    .uop_i        (uop_dec),
    .valid_o      (valid_o),
    .ins1_valid_o (ins1_valid_o),
    .bundle_pc_o  (bundle_pc_o),
    .uop_o        (uop_q)
  );

  // lane 0
  assign ins0_unit_o    = uop_q[0].unit;
  assign ins0_alu_op_o  = uop_q[0].alu_op;
  assign ins0_rs1_o     = uop_q[0].rs1;
  assign ins0_rs2_o     = uop_q[0].rs2;
  assign ins0_rd_o      = uop_q[0].rd;
  assign ins0_imm_o     = uop_q[0].imm;
  assign ins0_use_imm_o = uop_q[0].use_imm;
  assign ins0_rd_wr_o   = uop_q[0].rd_wr;
  assign ins0_rs1_rd_o  = uop_q[0].rs1_rd;
  assign ins0_rs2_rd_o  = uop_q[0].rs2_rd;
  assign ins0_illegal_o = uop_q[0].illegal;

  // lane 1, qualified by ins1_valid_o
  assign ins1_unit_o    = uop_q[1].unit;
  assign ins1_alu_op_o  = uop_q[1].alu_op;
  assign ins1_rs1_o     = uop_q[1].rs1;
  assign ins1_rs2_o     = uop_q[1].rs2;
  assign ins1_rd_o      = uop_q[1].rd;
  assign ins1_imm_o     = uop_q[1].imm;
  assign ins1_use_imm_o = uop_q[1].use_imm;
  assign ins1_rd_wr_o   = uop_q[1].rd_wr;
  assign ins1_rs1_rd_o  = uop_q[1].rs1_rd;
  assign ins1_rs2_rd_o  = uop_q[1].rs2_rd;
  assign ins1_illegal_o = uop_q[1].illegal;

endmodule

`default_nettype wire

/* testbench/decode_vectors.svh */
// fetch bundles and expected lane results for the decode testbench
// each entry gives the pc, both instruction words and the expected micro-op fields per lane
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

localparam int NUM_VEC = 15;

string                     vec_name  [NUM_VEC];
logic [`DEC_PC_W-1:0]      vec_pc    [NUM_VEC];
logic [`DEC_BUNDLE_W-1:0]  vec_word  [NUM_VEC];
logic                      vec_ins1  [NUM_VEC];
dec_unit_e                 exp_unit  [NUM_VEC][`DEC_LANES];
logic [3:0]                exp_alu   [NUM_VEC][`DEC_LANES];
logic [`DEC_XLEN-1:0]      exp_imm   [NUM_VEC][`DEC_LANES];
logic                      exp_rd_wr [NUM_VEC][`DEC_LANES];
logic                      exp_ill   [NUM_VEC][`DEC_LANES];
int                        vec_cnt;

// word is {hi, lo}; lane 1 expectations stay unchecked when ins1 is low
task automatic add_bundle(input string name, input logic [`DEC_PC_W-1:0] pc,
                          input logic [31:0] hi, input logic [31:0] lo, input logic ins1);
  vec_name[vec_cnt] = name;
  vec_pc[vec_cnt]   = pc;
  vec_word[vec_cnt] = {hi, lo};
  vec_ins1[vec_cnt] = ins1;
  vec_cnt++;
endtask

task automatic expect_lane(input int lane, input dec_unit_e unit, input logic [3:0] alu,
                           input logic [31:0] imm, input logic rd_wr, input logic ill);
  exp_unit[vec_cnt-1][lane]  = unit;
  exp_alu[vec_cnt-1][lane]   = alu;
  exp_imm[vec_cnt-1][lane]   = imm;
  exp_rd_wr[vec_cnt-1][lane] = rd_wr;
  exp_ill[vec_cnt-1][lane]   = ill;
endtask

task automatic load_vectors();
  vec_cnt = 0;
  // addi x1,x2,-5 / lw x5,8(x3)
  add_bundle("imm_i", 30'h040, 32'h0081A283, 32'hFFB10093, 1'b1);
  expect_lane(0, UNIT_ALU, 4'h0, 32'hFFFFFFFB, 1'b1, 1'b0);
  expect_lane(1, UNIT_LOAD, 4'h2, 32'h00000008, 1'b1, 1'b0);
  // sw x6,-12(x7) / beq x1,x2,-16
  add_bundle("imm_s_b", 30'h042, 32'hFE2088E3, 32'hFE63AA23, 1'b1);
  expect_lane(0, UNIT_STORE, 4'h2, 32'hFFFFFFF4, 1'b0, 1'b0);
  expect_lane(1, UNIT_BRANCH, 4'h0, 32'hFFFFFFF0, 1'b0, 1'b0);
  // lui x10,0x12345 / auipc x11,0xfffff
  add_bundle("imm_u", 30'h044, 32'hFFFFF597, 32'h12345537, 1'b1);
  expect_lane(0, UNIT_LUI, 4'h5, 32'h12345000, 1'b1, 1'b0);
  expect_lane(1, UNIT_AUIPC, 4'h7, 32'hFFFFF000, 1'b1, 1'b0);
  // jal x1,-4 / jalr x5,100(x6)
  add_bundle("imm_j", 30'h046, 32'h064302E7, 32'hFFDFF0EF, 1'b1);
  expect_lane(0, UNIT_JAL, 4'h7, 32'hFFFFFFFC, 1'b1, 1'b0);
  expect_lane(1, UNIT_JALR, 4'h0, 32'h00000064, 1'b1, 1'b0);
  add_bundle("add_sub", 30'h048, 32'h402081B3, 32'h002081B3, 1'b1);
  expect_lane(0, UNIT_ALU, 4'h0, 32'h00000000, 1'b1, 1'b0);
  expect_lane(1, UNIT_ALU, 4'h8, 32'h00000000, 1'b1, 1'b0);
  add_bundle("srl_sra", 30'h04A, 32'h4062D233, 32'h0062D233, 1'b1);
  expect_lane(0, UNIT_ALU, 4'h5, 32'h00000000, 1'b1, 1'b0);
  expect_lane(1, UNIT_ALU, 4'hD, 32'h00000000, 1'b1, 1'b0);
  add_bundle("srli_srai", 30'h04C, 32'h40345393, 32'h00345393, 1'b1);
  expect_lane(0, UNIT_ALU, 4'h5, 32'h00000003, 1'b1, 1'b0);
  expect_lane(1, UNIT_ALU, 4'hD, 32'h00000403, 1'b1, 1'b0);
  // xori x9,x9,-1 / blt x1,x2,+8
  add_bundle("xori_blt", 30'h04E, 32'h0020C463, 32'hFFF4C493, 1'b1);
  expect_lane(0, UNIT_ALU, 4'h4, 32'hFFFFFFFF, 1'b1, 1'b0);
  expect_lane(1, UNIT_BRANCH, 4'h4, 32'h00000008, 1'b0, 1'b0);
  // odd pc, high word moves to lane 0
  add_bundle("odd_pc_add", 30'h111, 32'h002081B3, 32'h00000000, 1'b0);
  expect_lane(0, UNIT_ALU, 4'h0, 32'h00000000, 1'b1, 1'b0);
  add_bundle("odd_pc_sw", 30'h123, 32'hFE63AA23, 32'h002081B3, 1'b0);
  expect_lane(0, UNIT_STORE, 4'h2, 32'hFFFFFFF4, 1'b0, 1'b0);
  // addi with low bits 01 / load funct3 110
  add_bundle("ill_low_load", 30'h060, 32'h0081E283, 32'hFFB10091, 1'b1);
  expect_lane(0, UNIT_NONE, 4'h0, 32'hFFFFFFFB, 1'b0, 1'b1);
  expect_lane(1, UNIT_NONE, 4'h6, 32'h00000008, 1'b0, 1'b1);
  add_bundle("ill_store_branch", 30'h062, 32'hFE20A8E3, 32'hFE63BA23, 1'b1);
  expect_lane(0, UNIT_NONE, 4'h3, 32'hFFFFFFF4, 1'b0, 1'b1);
  expect_lane(1, UNIT_NONE, 4'h2, 32'hFFFFFFF0, 1'b0, 1'b1);
  // OP funct7 0x20 with funct3 001 / ecall, which has no listed opcode
  add_bundle("ill_op_opcode", 30'h064, 32'h00000073, 32'h402091B3, 1'b1);
  expect_lane(0, UNIT_NONE, 4'h9, 32'h00000000, 1'b0, 1'b1);
  expect_lane(1, UNIT_NONE, 4'h0, 32'h00000000, 1'b0, 1'b1);
  add_bundle("ill_shift_jalr", 30'h066, 32'h064312E7, 32'h40109093, 1'b1);
  expect_lane(0, UNIT_NONE, 4'h1, 32'h00000401, 1'b0, 1'b1);
  expect_lane(1, UNIT_NONE, 4'h1, 32'h00000064, 1'b0, 1'b1);
  // ret / nop, both target x0
  add_bundle("rd_zero", 30'h068, 32'h00000013, 32'h00008067, 1'b1);
  expect_lane(0, UNIT_JALR, 4'h0, 32'h00000000, 1'b0, 1'b0);
  expect_lane(1, UNIT_ALU, 4'h0, 32'h00000000, 1'b0, 1'b0);
endtask

`endif

/* testbench/decode_tb.sv */
// testbench for the dual-issue decode stage
// runs the vector table straight through, again under random rename stalls, then a flush
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module decode_tb import decode_pkg::*; ();
  localparam int RESET_CYCLES = 4;

  logic                      cpu_clk;
  logic                      rst_n;
  logic                      flush;
  logic                      icache_valid;
  logic [`DEC_BUNDLE_W-1:0]  instruction;
  logic [`DEC_PC_W-1:0]      if2_pc;
  logic                      rn_busy;
  logic                      busy;
  logic                      valid;
  logic                      ins1_valid;
  logic [`DEC_PC_W-1:0]      bundle_pc;
  dec_unit_e                 out_unit    [`DEC_LANES];
  logic [3:0]                out_alu     [`DEC_LANES];
  logic [`DEC_REG_W-1:0]     out_rs1     [`DEC_LANES];
  logic [`DEC_REG_W-1:0]     out_rs2     [`DEC_LANES];
  logic [`DEC_REG_W-1:0]     out_rd      [`DEC_LANES];
  logic [`DEC_XLEN-1:0]      out_imm     [`DEC_LANES];
  logic                      out_use_imm [`DEC_LANES];
  logic                      out_rd_wr   [`DEC_LANES];
  logic                      out_rs1_rd  [`DEC_LANES];
  logic                      out_rs2_rd  [`DEC_LANES];
  logic                      out_ill     [`DEC_LANES];

  logic [31:0]  lfsr;
  int           exp_q [$];
  int           drive_idx;
  string        phase;
  int           err_cnt;
  int           pass_cnt;
  int           fail_cnt;
  int           cycle_cnt;

  `include "decode_vectors.svh"

  // two passes over the table plus reset and the flush sequence
  localparam int MAX_CYCLES = 4 * 2 * NUM_VEC + RESET_CYCLES + 100;

  dual_decode_top dut0 (
    .cpu_clk_i      (cpu_clk),
    .rst_n_i        (rst_n),
    .flush_i        (flush),
    .icache_valid_i (icache_valid),
    .instruction_i  (instruction),
    .if2_pc_i       (if2_pc),
    .rn_busy_i      (rn_busy),
    .busy_o         (busy),
    .valid_o        (valid),
    .ins1_valid_o   (ins1_valid),
    .bundle_pc_o    (bundle_pc),
    .ins0_unit_o    (out_unit[0]),
    .ins0_alu_op_o  (out_alu[0]),
    .ins0_rs1_o     (out_rs1[0]),
    .ins0_rs2_o     (out_rs2[0]),
    .ins0_rd_o      (out_rd[0]),
    .ins0_imm_o     (out_imm[0]),
    .ins0_use_imm_o (out_use_imm[0]),
    .ins0_rd_wr_o   (out_rd_wr[0]),
    .ins0_rs1_rd_o  (out_rs1_rd[0]),
    .ins0_rs2_rd_o  (out_rs2_rd[0]),
    .ins0_illegal_o (out_ill[0]),
    .ins1_unit_o    (out_unit[1]),
    .ins1_alu_op_o  (out_alu[1]),
    .ins1_rs1_o     (out_rs1[1]),
    .ins1_rs2_o     (out_rs2[1]),
    .ins1_rd_o      (out_rd[1]),
    .ins1_imm_o     (out_imm[1]),
    .ins1_use_imm_o (out_use_imm[1]),
    .ins1_rd_wr_o   (out_rd_wr[1]),
    .ins1_rs1_rd_o  (out_rs1_rd[1]),
    .ins1_rs2_rd_o  (out_rs2_rd[1]),
    .ins1_illegal_o (out_ill[1])
  );

  always #20 cpu_clk = ~cpu_clk;

  // galois lfsr, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  // instruction word that lands in a lane, odd pc moves the high word down
  function automatic logic [31:0] lane_word(input int idx, input int lane);
    if (vec_pc[idx][0] || lane == 1) begin
      return vec_word[idx][63:32];
    end
    return vec_word[idx][31:0];
  endfunction

  task automatic check_unit(input string test, input string field,
                            input dec_unit_e exp, input dec_unit_e act);
    if (exp !== act) begin
      $display("error %s %s: expected %0d, actual %0d", test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_imm(input string test, input string field,
                           input logic [`DEC_XLEN-1:0] exp, input logic [`DEC_XLEN-1:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h, actual %h", test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_op(input string test, input string field,
                          input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h, actual %h", test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input string test, input string field,
                           input logic [`DEC_REG_W-1:0] exp, input logic [`DEC_REG_W-1:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %0d, actual %0d", test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string test, input string field,
                            input logic exp, input logic act);
    if (exp !== act) begin
      $display("error %s %s: expected %b, actual %b", test, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_pc(input string test, input logic [`DEC_PC_W-1:0] exp,
                          input logic [`DEC_PC_W-1:0] act);
    if (exp !== act) begin
      $display("error %s bundle_pc: expected %h, actual %h", test, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("pass %s", name);
    end else begin
      fail_cnt++;
      $display("fail %s", name);
    end
  endtask

  // rename takes the oldest expected bundle
  task automatic compare_bundle();
    int          idx;
    int          errs_before;
    string       name;
    logic [31:0] w;
    logic [4:0]  opc;
    logic        ill;
    dec_unit_e   u;
    if (exp_q.size() == 0) begin
      $display("valid_o was high with no bundle outstanding, pc %h", bundle_pc);
      err_cnt++;
    end else begin
      idx = exp_q.pop_front();
      errs_before = err_cnt;
      name = {phase, "/", vec_name[idx]};
      check_pc(name, vec_pc[idx], bundle_pc);
      check_flag(name, "ins1_valid", vec_ins1[idx], ins1_valid);
      for (int l = 0; l < `DEC_LANES; l++) begin
        if (l == 0 || vec_ins1[idx]) begin
          w   = lane_word(idx, l);
          opc = w[6:2];
          ill = exp_ill[idx][l];
          u   = exp_unit[idx][l];
          check_unit(name, $sformatf("lane%0d unit", l), u, out_unit[l]);
          check_op(name, $sformatf("lane%0d alu_op", l), exp_alu[idx][l], out_alu[l]);
          check_imm(name, $sformatf("lane%0d imm", l), exp_imm[idx][l], out_imm[l]);
          check_flag(name, $sformatf("lane%0d rd_wr", l), exp_rd_wr[idx][l], out_rd_wr[l]);
          check_flag(name, $sformatf("lane%0d illegal", l), ill, out_ill[l]);
          check_reg(name, $sformatf("lane%0d rs1", l), w[19:15], out_rs1[l]);
          check_reg(name, $sformatf("lane%0d rs2", l), w[24:20], out_rs2[l]);
          check_reg(name, $sformatf("lane%0d rd", l), w[11:7], out_rd[l]);
          check_flag(name, $sformatf("lane%0d use_imm", l), opc == 5'b00100, out_use_imm[l]);
          check_flag(name, $sformatf("lane%0d rs1_rd", l),
                     !ill && u != UNIT_LUI && u != UNIT_AUIPC && u != UNIT_JAL, out_rs1_rd[l]);
          check_flag(name, $sformatf("lane%0d rs2_rd", l),
                     !ill && (opc == 5'b01100 || opc == 5'b11000 || opc == 5'b01000),
                     out_rs2_rd[l]);
        end
      end
      report_test(name, errs_before);
    end
  endtask

  // scoreboard, sees the values held since the last falling edge
  always @(posedge cpu_clk) begin
    if (rst_n) begin
      if (valid && !rn_busy) begin
        compare_bundle();
      end
      if (icache_valid && busy) begin
        $display("a bundle was offered while busy_o was high, pc %h", if2_pc);
        err_cnt++;
      end
      if (flush) begin
        exp_q.delete();
      end else if (icache_valid && !busy) begin
        exp_q.push_back(drive_idx);
      end
    end
  end

  always @(posedge cpu_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic run_table(input logic rand_stall);
    int i;
    i = 0;
    while (i < NUM_VEC) begin
      @(negedge cpu_clk);
      rn_busy = rand_stall ? next_bit() : 1'b0;
      if (busy) begin
        icache_valid = 1'b0;
      end else begin
        icache_valid = 1'b1;
        instruction  = vec_word[i];
        if2_pc       = vec_pc[i];
        drive_idx    = i;
        i++;
      end
    end
    @(negedge cpu_clk);
    icache_valid = 1'b0;
    rn_busy      = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge cpu_clk);
    end
  endtask

  // one bundle in the issue register and one in the skid entry, then flush
  task automatic run_flush();
    int errs_before;
    errs_before = err_cnt;
    @(negedge cpu_clk);
    rn_busy      = 1'b0;
    icache_valid = 1'b1;
    instruction  = vec_word[0];
    if2_pc       = vec_pc[0];
    drive_idx    = 0;
    @(negedge cpu_clk);
    rn_busy      = 1'b1;
    instruction  = vec_word[1];
    if2_pc       = vec_pc[1];
    drive_idx    = 1;
    @(negedge cpu_clk);
    check_flag("flush", "valid_o before flush", 1'b1, valid);
    check_flag("flush", "busy_o before flush", 1'b1, busy);
    icache_valid = 1'b0;
    flush        = 1'b1;
    @(negedge cpu_clk);
    flush = 1'b0;
    check_flag("flush", "valid_o", 1'b0, valid);
    check_flag("flush", "busy_o", 1'b0, busy);
    rn_busy = 1'b0;
    repeat (3) begin
      @(negedge cpu_clk);
      check_flag("flush", "valid_o after release", 1'b0, valid);
    end
    report_test("flush", errs_before);
  endtask

  initial begin : main_seq
    int errs_before;
    cpu_clk      = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    icache_valid = 1'b0;
    instruction  = '0;
    if2_pc       = '0;
    rn_busy      = 1'b0;
    lfsr         = 32'h491a7828;
    drive_idx    = 0;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    cycle_cnt    = 0;
    load_vectors();
    repeat (RESET_CYCLES) @(negedge cpu_clk);
    rst_n = 1'b1;
    @(negedge cpu_clk);
    errs_before = err_cnt;
    check_flag("reset", "valid_o", 1'b0, valid);
    check_flag("reset", "busy_o", 1'b0, busy);
    report_test("reset", errs_before);
    phase = "direct";
    run_table(1'b0);
    phase = "stall";
    run_table(1'b1);
    run_flush();
    $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
+incdir+testbench
logic/rv_isa_pkg.sv
logic/decode_pkg.sv
logic/fetch_bundle_if.sv
logic/fetch_skid_buffer.sv
logic/rv_lane_decoder.sv
logic/issue_register.sv
logic/dual_decode_top.sv
testbench/decode_tb.sv
